//--- hw/cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// Width of every data word and every address on ROM and RAM
`define CPU_DATA_W 8

// Number of interrupt lines into the sequencer
`define CPU_IRQ_N 2

// ROM locations that hold the start address of each thread
`define CPU_VECTOR_IRQ0 8'hFF
`define CPU_VECTOR_IRQ1 8'hFE

// Address left on the bus when nothing is read or written
`define CPU_BUS_IDLE_ADDR 8'hFF

// Program counter value after reset
// ROM location 0 is expected to hold the idle instruction
`define CPU_RESET_PC 8'h00

`endif

//--- hw/cpuPkg.sv
`include "cpu_settings.svh"

package cpuPkg;

    // One data byte or one address
    typedef logic [`CPU_DATA_W-1:0] byteT;

    // One bit per interrupt line, used for raise and for acknowledge
    typedef logic [`CPU_IRQ_N-1:0] irqVecT;

    //////////////////////////////////////////////////
    // Sequencer states
    // Upper nibble groups the states of one instruction
    typedef enum logic [7:0] {
        stIdle         = 8'hF0,
        stThreadFetch  = 8'hF1,
        stThreadLoad   = 8'hF2,
        stThreadSettle = 8'hF3,
        stDispatch     = 8'h00,
        stReadToA      = 8'h10,
        stReadToB      = 8'h11,
        stReadAddr     = 8'h12,
        stReadWait     = 8'h13,
        stReadLoad     = 8'h14,
        stWriteFromA   = 8'h20,
        stWriteFromB   = 8'h21,
        stWriteIssue   = 8'h22,
        stMathsToA     = 8'h30,
        stMathsToB     = 8'h31,
        stMathsSettle  = 8'h32,
        stBranch       = 8'h40,
        stBranchSkip   = 8'h41,
        stGoto         = 8'h50,
        stGotoLoad     = 8'h51,
        stGotoSettle   = 8'h52
    } seqStateT;

    // Lower nibble of an instruction byte
    typedef enum logic [3:0] {
        opReadA  = 4'h0,
        opReadB  = 4'h1,
        opWriteA = 4'h2,
        opWriteB = 4'h3,
        opMathsA = 4'h4,
        opMathsB = 4'h5,
        opBranch = 4'h6,
        opGoto   = 4'h7,
        opIdle   = 4'h8
    } opcodeT;

    // Upper nibble of a maths or branch instruction
    typedef enum logic [3:0] {
        aluAdd      = 4'h0,
        aluAnd      = 4'h1,
        aluLessThan = 4'h2
    } aluOpT;

    //////////////////////////////////////////////////
    // Registered request towards the data memory
    typedef struct packed {
        byteT addr;
        byteT wrData;
        logic wrEn;
    } busReqT;

    // Per-state control word from the sequencer to the datapath
    typedef struct packed {
        logic regSelLoad;
        logic regSelVal;
        logic loadFromBus;
        logic loadA;
        logic loadB;
        logic busRead;
        logic busWrite;
    } dpCtrlT;

endpackage

//--- hw/arithmeticUnit.sv
`timescale 1ns/1ps

module arithmeticUnit (
    input  cpuPkg::byteT  RegA,
    input  cpuPkg::byteT  RegB,
    input  cpuPkg::aluOpT OpCode,
    output cpuPkg::byteT  AluResult
);
    import cpuPkg::*;

    // Candidate results of the three supported operations
    byteT sumResult;
    byteT andResult;
    byteT lessResult;

    // Sum wraps around at the byte width
    assign sumResult = RegA + RegB;

    // Bitwise and of both operands
    assign andResult = RegA & RegB;

    // Unsigned compare
    // gives 1 when A is below B, zero otherwise
    assign lessResult = byteT'(RegA < RegB);

    //////////////////////////////////////////////////
    // Operation select
    // Pure combinational path, result is valid in the same cycle
    always_comb begin
        case (OpCode)
            aluAdd: begin
                AluResult = sumResult;
            end
            aluAnd: begin
                AluResult = andResult;
            end
            aluLessThan: begin
                AluResult = lessResult;
            end
            // Any unsupported code reads as zero
            // A branch on such a code is never taken
            default: begin
                AluResult = '0;
            end
        endcase
    end

endmodule

//--- hw/instructionSequencer.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module instructionSequencer (
    input  logic            CLK,
    input  logic            RESET,
    output cpuPkg::byteT    RomAddr,
    input  cpuPkg::byteT    RomData,
    input  cpuPkg::irqVecT  IrqRaise,
    output cpuPkg::irqVecT  IrqAck,
    input  cpuPkg::byteT    AluResult,
    output cpuPkg::dpCtrlT  DpCtrl
);
    import cpuPkg::*;

    // State and program position
    seqStateT   currState;
    seqStateT   nextState;
    byteT       currPc;
    byteT       nextPc;
    logic [1:0] currOffset;
    logic [1:0] nextOffset;

    // Acknowledge is registered so it lasts exactly one cycle
    irqVecT     currAck;
    irqVecT     nextAck;

    // Lower nibble of the ROM byte is the instruction code
    opcodeT     romOpcode;

    assign romOpcode = opcodeT'(RomData[3:0]);

    // ROM is addressed by program counter plus operand offset
    assign RomAddr = currPc + byteT'(currOffset);
    assign IrqAck  = currAck;

    //////////////////////////////////////////////////
    // Registers
    always_ff @(posedge CLK) begin
        if (RESET) begin
            // Reset lands in dispatch
            // ROM location 0 then sends the machine to idle
            currState  <= stDispatch;
            currPc     <= `CPU_RESET_PC;
            currOffset <= 2'd0;
            currAck    <= '0;
        end else begin
            currState  <= nextState;
            currPc     <= nextPc;
            currOffset <= nextOffset;
            currAck    <= nextAck;
        end
    end

    //////////////////////////////////////////////////
    // Next state and program counter
    always_comb begin
        // Hold by default, offset and acknowledge drop back to zero
        nextState  = currState;
        nextPc     = currPc;
        nextOffset = 2'd0;
        nextAck    = '0;

        case (currState)
            // Wait for an interrupt, line 0 first
            stIdle: begin
                if (IrqRaise[0]) begin
                    nextState = stThreadFetch;
                    nextPc    = `CPU_VECTOR_IRQ0;
                    nextAck   = irqVecT'(1);
                end else if (IrqRaise[1]) begin
                    nextState = stThreadFetch;
                    nextPc    = `CPU_VECTOR_IRQ1;
                    nextAck   = irqVecT'(2);
                end
            end
            // Vector address is on the ROM
            stThreadFetch: begin
                nextState = stThreadLoad;
            end
            // Vector byte has arrived
            stThreadLoad: begin
                nextState = stThreadSettle;
                nextPc    = RomData;
            end
            // Let the first instruction come out of the ROM
            stThreadSettle: begin
                nextState = stDispatch;
            end

            // Decode the instruction, point the ROM at its operand
            stDispatch: begin
                nextOffset = 2'd1;
                case (romOpcode)
                    opReadA:  nextState = stReadToA;
                    opReadB:  nextState = stReadToB;
                    opWriteA: nextState = stWriteFromA;
                    opWriteB: nextState = stWriteFromB;
                    opMathsA: nextState = stMathsToA;
                    opMathsB: nextState = stMathsToB;
                    opBranch: nextState = stBranch;
                    opGoto:   nextState = stGoto;
                    opIdle:   nextState = stIdle;
                    // Unknown codes end the thread
                    default:  nextState = stIdle;
                endcase
            end

            // Memory read, operand byte is the data address
            stReadToA, stReadToB: begin
                nextState = stReadAddr;
            end
            stReadAddr: begin
                nextState = stReadWait;
            end
            // Step over opcode and operand two cycles ahead
            stReadWait: begin
                nextState = stReadLoad;
                nextPc    = currPc + byteT'(2);
            end
            stReadLoad: begin
                nextState = stDispatch;
            end

            // Memory write, address arrives one cycle later
            stWriteFromA, stWriteFromB: begin
                nextState = stWriteIssue;
                nextPc    = currPc + byteT'(2);
            end
            stWriteIssue: begin
                nextState = stDispatch;
            end

            // Maths result is taken while the opcode is on the ROM
            stMathsToA, stMathsToB: begin
                nextState = stMathsSettle;
                nextPc    = currPc + byteT'(1);
            end
            stMathsSettle: begin
                nextState = stDispatch;
            end

            // Branch on nonzero result
            // Taken path reuses the goto load of the target
            stBranch: begin
                if (AluResult != '0) begin
                    nextState = stGotoLoad;
                    nextPc    = currPc + byteT'(1);
                end else begin
                    nextState = stBranchSkip;
                    nextPc    = currPc + byteT'(2);
                end
            end
            stBranchSkip: begin
                nextState = stDispatch;
            end

            // Unconditional jump to the operand byte
            stGoto: begin
                nextState = stGotoLoad;
            end
            stGotoLoad: begin
                nextState = stGotoSettle;
                nextPc    = RomData;
            end
            stGotoSettle: begin
                nextState = stDispatch;
            end

            default: begin
                nextState = stIdle;
            end
        endcase
    end

    //////////////////////////////////////////////////
    // Datapath control per state
    always_comb begin
        DpCtrl = '0;
        case (currState)
            stReadToA, stWriteFromA: begin
                DpCtrl.regSelLoad = 1'b1;
                DpCtrl.regSelVal  = 1'b0;
            end
            stReadToB, stWriteFromB: begin
                DpCtrl.regSelLoad = 1'b1;
                DpCtrl.regSelVal  = 1'b1;
            end
            // Operand byte becomes the read address
            stReadAddr: begin
                DpCtrl.busRead = 1'b1;
            end
            // Read data is on the bus now
            stReadLoad: begin
                DpCtrl.loadFromBus = 1'b1;
            end
            stWriteIssue: begin
                DpCtrl.busWrite = 1'b1;
            end
            stMathsToA: begin
                DpCtrl.loadA = 1'b1;
            end
            stMathsToB: begin
                DpCtrl.loadB = 1'b1;
            end
            default: begin
                DpCtrl = '0;
            end
        endcase
    end

endmodule

//--- hw/operandDatapath.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module operandDatapath (
    input  logic            CLK,
    input  logic            RESET,
    input  cpuPkg::dpCtrlT  DpCtrl,
    input  cpuPkg::byteT    RomData,
    input  cpuPkg::byteT    BusDataIn,
    input  cpuPkg::byteT    AluResult,
    output cpuPkg::byteT    RegA,
    output cpuPkg::byteT    RegB,
    output cpuPkg::busReqT  BusReq
);
    import cpuPkg::*;

    // Register select, 0 picks A and 1 picks B
    logic regSel;

    // Bus request fields
    byteT busAddr;
    byteT busData;
    logic busWe;

    // Register chosen for the next write
    byteT selReg;

    assign selReg = regSel ? RegB : RegA;

    //////////////////////////////////////////////////
    // Control state of the bus and the select
    always_ff @(posedge CLK) begin
        if (RESET) begin
            regSel  <= 1'b0;
            busAddr <= `CPU_BUS_IDLE_ADDR;
            busWe   <= 1'b0;
        end else begin
            if (DpCtrl.regSelLoad) begin
                regSel <= DpCtrl.regSelVal;
            end
            // Address falls back to idle when nothing is accessed
            if (DpCtrl.busRead || DpCtrl.busWrite) begin
                busAddr <= RomData;
            end else begin
                busAddr <= `CPU_BUS_IDLE_ADDR;
            end
            // Strobe is high for a single cycle
            busWe <= DpCtrl.busWrite;
        end
    end

    // Write data holds its last value between writes
    always_ff @(posedge CLK) begin
        if (DpCtrl.busWrite) begin
            busData <= selReg;
        end
    end

    //////////////////////////////////////////////////
    // Operand registers
    always_ff @(posedge CLK) begin
        if (DpCtrl.loadFromBus && !regSel) begin
            RegA <= BusDataIn;
        end else if (DpCtrl.loadA) begin
            RegA <= AluResult;
        end
        if (DpCtrl.loadFromBus && regSel) begin
            RegB <= BusDataIn;
        end else if (DpCtrl.loadB) begin
            RegB <= AluResult;
        end
    end

    assign BusReq = '{addr: busAddr, wrData: busData, wrEn: busWe};

endmodule

//--- hw/processorTop.sv
`timescale 1ns/1ps

module processorTop (
    input  logic            CLK,
    input  logic            RESET,
    output cpuPkg::busReqT  BusReq,
    input  cpuPkg::byteT    BusDataIn,
    output cpuPkg::byteT    RomAddr,
    input  cpuPkg::byteT    RomData,
    input  cpuPkg::irqVecT  IrqRaise,
    output cpuPkg::irqVecT  IrqAck
);
    import cpuPkg::*;

    // Per-state control from sequencer to datapath
    dpCtrlT dpCtrl;

    // Operands and result shared by all three blocks
    byteT   regA;
    byteT   regB;
    byteT   aluResult;

    //////////////////////////////////////////////////
    // State machine, program counter and interrupts
    instructionSequencer i_instructionSequencer (
        .CLK       (CLK),
        .RESET     (RESET),
        .RomAddr   (RomAddr),
        .RomData   (RomData),
        .IrqRaise  (IrqRaise),
        .IrqAck    (IrqAck),
        .AluResult (aluResult),
        .DpCtrl    (dpCtrl)
    );

    // A and B registers with the bus request
    operandDatapath i_operandDatapath (
        .CLK       (CLK),
        .RESET     (RESET),
        .DpCtrl    (dpCtrl),
        .RomData   (RomData),
        .BusDataIn (BusDataIn),
        .AluResult (aluResult),
        .RegA      (regA),
        .RegB      (regB),
        .BusReq    (BusReq)
    );

    // Operation code is the upper nibble of the instruction on the ROM
    arithmeticUnit i_arithmeticUnit (
        .RegA      (regA),
        .RegB      (regB),
        .OpCode    (aluOpT'(RomData[7:4])),
        .AluResult (aluResult)
    );

endmodule

//--- verification/processorAssertions.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module processorAssertions (
    input logic            CLK,
    input logic            RESET,
    input cpuPkg::busReqT  BusReq,
    input cpuPkg::irqVecT  IrqAck
);
    import cpuPkg::*;

    // Address the datapath shows between accesses
    localparam byteT IDLE_ADDR = `CPU_BUS_IDLE_ADDR;

    //////////////////////////////////////////////////
    // Interrupt acknowledge

    // Only one line is served at a time
    ackOneHot: assert property (@(posedge CLK) disable iff (RESET)
        IrqAck != 2'b11)
        else $error("Both interrupt lines acknowledged in the same cycle");

    // Acknowledge is a single-cycle pulse
    ackSingleCycle: assert property (@(posedge CLK) disable iff (RESET)
        (IrqAck != '0) |=> (IrqAck == '0))
        else $error("Interrupt acknowledge held for more than one cycle");

    //////////////////////////////////////////////////
    // Bus request

    // Reset clears the strobe on the following edge
    noWriteInReset: assert property (@(posedge CLK)
        RESET |=> !BusReq.wrEn)
        else $error("Bus write strobe high while reset is active");

    // A write is followed by dispatch, so the bus goes back to idle
    idleAfterWrite: assert property (@(posedge CLK) disable iff (RESET)
        BusReq.wrEn |=> (!BusReq.wrEn && BusReq.addr == IDLE_ADDR))
        else $error("Bus address not idle in the cycle after a write");

endmodule

//--- verification/processorTb.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module processorTb;
    import cpuPkg::*;

    localparam int   ROW_N      = 10;
    localparam int   WAIT_LIMIT = 200;
    // Result addresses used by the two threads
    localparam byteT ADDR_SUM   = 8'h80;
    localparam byteT ADDR_SEL   = 8'h81;
    localparam byteT ADDR_AND   = 8'h82;

    logic   CLK;
    logic   RESET;
    busReqT busReq;
    byteT   busDataIn;
    byteT   romAddr;
    byteT   romData;
    irqVecT irqRaise;
    irqVecT irqAck;

    // Memory contents and the operand preload port of the RAM model
    byteT   rom [256];
    byteT   ram [256];
    logic   preload;
    byteT   preA;
    byteT   preB;

    // Stimulus table with expected results
    string  rowName [ROW_N];
    irqVecT rowRaise [ROW_N];
    byteT   rowA [ROW_N];
    byteT   rowB [ROW_N];
    byteT   expSum [ROW_N];
    byteT   expAnd [ROW_N];
    byteT   expSel [ROW_N];
    integer seed;
    integer rnd;

    processorTop i_processorTop (
        .CLK       (CLK),
        .RESET     (RESET),
        .BusReq    (busReq),
        .BusDataIn (busDataIn),
        .RomAddr   (romAddr),
        .RomData   (romData),
        .IrqRaise  (irqRaise),
        .IrqAck    (irqAck)
    );

    bind processorTop processorAssertions i_processorAssertions (
        .CLK    (CLK),
        .RESET  (RESET),
        .BusReq (BusReq),
        .IrqAck (IrqAck)
    );

    // 40 ns period
    always #20 CLK = ~CLK;

    //////////////////////////////////////////////////
    // Synchronous memories with data one cycle after the address
    always @(posedge CLK) begin
        romData <= rom[romAddr];
    end

    always @(posedge CLK) begin
        if (preload) begin
            ram[0] <= preA;
            ram[1] <= preB;
        end else if (busReq.wrEn) begin
            ram[busReq.addr] <= busReq.wrData;
        end
        busDataIn <= ram[busReq.addr];
    end

    task automatic loadMemories();
        byteT addrByte;
        for (int i = 0; i < 256; i++) begin
            addrByte = byteT'(i);
            // Unused ROM decodes as idle with an upper nibble that follows the address
            rom[i] = {addrByte[7:4] ^ addrByte[3:0], 4'h8};
            ram[i] = addrByte ^ 8'hA5;
        end
        rom[0] = 8'h08;
        rom[`CPU_VECTOR_IRQ0] = 8'h10;
        rom[`CPU_VECTOR_IRQ1] = 8'h40;
        // Thread 0 writes the sum from A and the and from B
        rom[8'h10] = 8'h00;
        rom[8'h11] = 8'h00;
        rom[8'h12] = 8'h01;
        rom[8'h13] = 8'h01;
        rom[8'h14] = 8'h04;
        rom[8'h15] = 8'h02;
        rom[8'h16] = ADDR_SUM;
        rom[8'h17] = 8'h15;
        rom[8'h18] = 8'h03;
        rom[8'h19] = ADDR_AND;
        rom[8'h1A] = 8'h08;
        // Thread 1 writes the larger operand to 0x81
        rom[8'h40] = 8'h00;
        rom[8'h41] = 8'h00;
        rom[8'h42] = 8'h01;
        rom[8'h43] = 8'h01;
        rom[8'h44] = 8'h26;
        rom[8'h45] = 8'h4A;
        rom[8'h46] = 8'h02;
        rom[8'h47] = ADDR_SEL;
        rom[8'h48] = 8'h07;
        rom[8'h49] = 8'h4C;
        rom[8'h4A] = 8'h03;
        rom[8'h4B] = ADDR_SEL;
        rom[8'h4C] = 8'h08;
    endtask

    //////////////////////////////////////////////////
    // Stimulus table
    task automatic addRow(input int idx, input string name, input irqVecT raise,
                          input byteT a, input byteT b);
        rowName[idx]  = name;
        rowRaise[idx] = raise;
        rowA[idx]     = a;
        rowB[idx]     = b;
        expSum[idx]   = a + b;
        expAnd[idx]   = byteT'(a + b) & b;
        expSel[idx]   = (a < b) ? b : a;
    endtask

    task automatic buildTable();
        irqVecT raise;
        addRow(0, "equalOps", 2'b01, 8'h5A, 8'h5A);
        addRow(1, "wrapSum", 2'b01, 8'hF0, 8'h25);
        addRow(2, "branchUntaken", 2'b10, 8'h33, 8'h33);
        addRow(3, "branchTaken", 2'b10, 8'h12, 8'h80);
        addRow(4, "bothLines", 2'b11, 8'hC8, 8'h64);
        for (int k = 5; k < ROW_N; k++) begin
            rnd   = $random(seed);
            raise = (rnd[17:16] == 2'b00) ? 2'b11 : rnd[17:16];
            addRow(k, $sformatf("random%0d", k), raise, rnd[7:0], rnd[15:8]);
        end
    endtask

    //////////////////////////////////////////////////
    // Timing, failure and compare helpers

    // Sample and drive one ns after the rising edge
    task automatic tick();
        @(posedge CLK);
        #1;
    endtask

    task automatic abortRun(input string reason);
        $display("ERROR: %s", reason);
        $display("Regression failed");
        $fatal(1, "stopped at first failure");
    endtask

    function automatic busReqT makeWrite(input byteT addr, input byteT data);
        busReqT req;
        req.addr   = addr;
        req.wrData = data;
        req.wrEn   = 1'b1;
        return req;
    endfunction

    task automatic checkAck(input string name, input irqVecT expected, input irqVecT actual);
        if (actual !== expected) begin
            $display("MISMATCH %s: expected IrqAck %b, actual %b", name, expected, actual);
            abortRun("interrupt acknowledge mismatch");
        end
    endtask

    task automatic checkWrite(input string name, input busReqT expected, input busReqT actual);
        if (actual !== expected) begin
            $display("MISMATCH %s: expected addr %h data %h, actual addr %h data %h",
                     name, expected.addr, expected.wrData, actual.addr, actual.wrData);
            abortRun("bus write mismatch");
        end
    endtask

    task automatic checkRomAddr(input string name, input byteT expected, input byteT actual);
        if (actual !== expected) begin
            $display("MISMATCH %s: expected RomAddr %h, actual %h", name, expected, actual);
            abortRun("ROM address mismatch");
        end
    endtask

    task automatic waitAck(input string name, input irqVecT expected);
        irqVecT seen;
        int     count;
        seen  = '0;
        count = 0;
        while (seen == '0 && count < WAIT_LIMIT) begin
            tick();
            if (busReq.wrEn) begin
                abortRun({name, ": bus write while waiting for an acknowledge"});
            end
            seen  = irqAck;
            count = count + 1;
        end
        if (seen == '0) begin
            abortRun({name, ": no interrupt acknowledge before the timeout"});
        end
        checkAck(name, expected, seen);
    endtask

    task automatic waitWrite(input string name, input busReqT expected);
        logic found;
        int   count;
        found = 1'b0;
        count = 0;
        while (!found && count < WAIT_LIMIT) begin
            tick();
            found = busReq.wrEn;
            count = count + 1;
        end
        if (!found) begin
            abortRun({name, ": no bus write before the timeout"});
        end
        checkWrite(name, expected, busReq);
    endtask

    // Idle code 8 on the ROM marks the end of a thread
    task automatic waitIdle(input string name);
        logic idle;
        int   count;
        idle  = 1'b0;
        count = 0;
        while (!idle && count < WAIT_LIMIT) begin
            tick();
            if (busReq.wrEn) begin
                abortRun({name, ": unexpected bus write before idle"});
            end
            idle  = (romData[3:0] == 4'h8);
            count = count + 1;
        end
        if (!idle) begin
            abortRun({name, ": processor did not return to idle"});
        end
    endtask

    // One table row with the line 0 thread first when both lines are raised
    task automatic applyRow(input int i);
        tick();
        preA    = rowA[i];
        preB    = rowB[i];
        preload = 1'b1;
        tick();
        preload  = 1'b0;
        irqRaise = rowRaise[i];
        if (rowRaise[i][0]) begin
            waitAck({rowName[i], "/ack0"}, 2'b01);
            // Start vector location is on the ROM address in the acknowledge cycle
            checkRomAddr({rowName[i], "/vector0"}, `CPU_VECTOR_IRQ0, romAddr);
            irqRaise[0] = 1'b0;
            waitWrite({rowName[i], "/sum"}, makeWrite(ADDR_SUM, expSum[i]));
            waitWrite({rowName[i], "/and"}, makeWrite(ADDR_AND, expAnd[i]));
            waitIdle({rowName[i], "/idle0"});
        end
        if (rowRaise[i][1]) begin
            waitAck({rowName[i], "/ack1"}, 2'b10);
            checkRomAddr({rowName[i], "/vector1"}, `CPU_VECTOR_IRQ1, romAddr);
            irqRaise[1] = 1'b0;
            waitWrite({rowName[i], "/select"}, makeWrite(ADDR_SEL, expSel[i]));
            waitIdle({rowName[i], "/idle1"});
        end
    endtask

    //////////////////////////////////////////////////
    // Main sequence
    initial begin
        seed      = 32'h3be89608;
        CLK       = 1'b0;
        RESET     = 1'b1;
        irqRaise  = '0;
        romData   = '0;
        busDataIn = '0;
        preload   = 1'b0;
        preA      = '0;
        preB      = '0;
        loadMemories();
        buildTable();
        // Nothing is acknowledged or written during the 10 reset cycles
        for (int c = 0; c < 10; c++) begin
            tick();
            checkAck("reset", '0, irqAck);
            checkRomAddr("reset", `CPU_RESET_PC, romAddr);
            if (busReq.wrEn) begin
                abortRun("bus write during reset");
            end
        end
        RESET = 1'b0;
        // Quiet idle cycles before the first raise
        for (int c = 0; c < 8; c++) begin
            tick();
            checkAck("postReset", '0, irqAck);
            if (busReq.wrEn) begin
                abortRun("bus write before any interrupt");
            end
        end
        for (int i = 0; i < ROW_N; i++) begin
            applyRow(i);
        end
        $display("Regression passed");
        $finish;
    end

endmodule

//--- compile.f
+incdir+hw
hw/cpuPkg.sv
hw/arithmeticUnit.sv
hw/instructionSequencer.sv
hw/operandDatapath.sv
hw/processorTop.sv
verification/processorAssertions.sv
verification/processorTb.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f compile.f --top-module processorTb -o processorSim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/processorSim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation ended with status $status"
    exit "$status"
fi

exit 0
